// ==== src/board_macros.svh ====
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// ======================================================================
// bus geometry
// ======================================================================
`define AXIL_ADDR_W       4
`define AXIL_DATA_W       32
`define AXIL_STRB_W       (`AXIL_DATA_W / 8)

// switch bank width on the board
`define SW_W              18

// ======================================================================
// register map, byte offsets
// ======================================================================
`define REG_LED_OFS       4'h0
`define REG_SWITCH_OFS    4'h4
`define REG_DIGIT_EN_OFS  4'h8
`define REG_ID_OFS        4'hC

`define BOARD_ID          32'h5EC7_0001   // returned by the ID register

// reset stretch after all conditions are clear
`define RST_HOLD_CYCLES   16
`define RST_CNT_W         4               // holds 0 .. RST_HOLD_CYCLES-1

`endif

// ==== src/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // ======================================================================
    // bus response codes
    // ======================================================================
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,   // read-only register written
        DECERR = 2'b11    // nothing mapped there
    } axil_resp_e;

    // ======================================================================
    // register select, result of the address decode
    // ======================================================================
    typedef enum logic [2:0] {
        REG_LED,
        REG_SWITCH,
        REG_DIGIT_EN,
        REG_ID,
        REG_NONE
    } gpio_reg_e;

    // reset controller FSM
    typedef enum logic [1:0] {
        HOLD,    // some condition low
        COUNT,   // all clear, stretching the release
        RUN
    } rst_state_e;

endpackage

`default_nettype wire

// ==== src/reset_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "board_macros.svh"

module reset_ctrl (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  pll_locked,
    input  wire  key0,
    output logic sys_rst_n
);

    logic [1:0]               sync_q;   // two-flop synchronizer
    logic [`RST_CNT_W-1:0]    cnt;
    board_pkg::rst_state_e    state;
    board_pkg::rst_state_e    state_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n) sync_q <= 2'b00;
        else        sync_q <= {sync_q[0], pll_locked & key0};
    end

    // any low condition drops back to HOLD
    always_comb begin
        state_nxt = state;
        if (!sync_q[1]) begin
            state_nxt = board_pkg::HOLD;
        end else begin
            case (state)
                board_pkg::HOLD:  state_nxt = board_pkg::COUNT;
                board_pkg::COUNT: begin
                    if (cnt == `RST_CNT_W'(`RST_HOLD_CYCLES - 1)) state_nxt = board_pkg::RUN;
                end
                default:          state_nxt = board_pkg::RUN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= board_pkg::HOLD;
            cnt       <= '0;
            sys_rst_n <= 1'b0;
        end else begin
            state     <= state_nxt;
            sys_rst_n <= (state_nxt == board_pkg::RUN);   // high only in RUN
            if (state_nxt == board_pkg::HOLD) cnt <= '0;
            else if (state == board_pkg::HOLD) cnt <= `RST_CNT_W'(1);  // first hold cycle
            else if (state == board_pkg::COUNT) cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/axil_gpio_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "board_macros.svh"

module axil_gpio_regs (
    input  wire                          clk,
    input  wire                          sys_rst_n,

    // write address / data / response
    input  wire  [`AXIL_ADDR_W-1:0]      awaddr,
    input  wire                          awvalid,
    output logic                         awready,
    input  wire  [`AXIL_DATA_W-1:0]      wdata,
    input  wire  [`AXIL_STRB_W-1:0]      wstrb,
    input  wire                          wvalid,
    output logic                         wready,
    output board_pkg::axil_resp_e        bresp,
    output logic                         bvalid,
    input  wire                          bready,

    // read address / data
    input  wire  [`AXIL_ADDR_W-1:0]      araddr,
    input  wire                          arvalid,
    output logic                         arready,
    output logic [`AXIL_DATA_W-1:0]      rdata,
    output board_pkg::axil_resp_e        rresp,
    output logic                         rvalid,
    input  wire                          rready,

    // board side
    input  wire  [`SW_W-1:0]             sw,
    input  wire                          sensor_int,
    output logic [`AXIL_DATA_W-1:0]      led_reg,
    output logic [7:0]                   digit_en
);

    // ======================================================================
    // address decode
    // ======================================================================
    function automatic board_pkg::gpio_reg_e decode(input logic [`AXIL_ADDR_W-1:0] addr);
        case (addr)
            `REG_LED_OFS:      return board_pkg::REG_LED;
            `REG_SWITCH_OFS:   return board_pkg::REG_SWITCH;
            `REG_DIGIT_EN_OFS: return board_pkg::REG_DIGIT_EN;
            `REG_ID_OFS:       return board_pkg::REG_ID;
            default:           return board_pkg::REG_NONE;   // unaligned
        endcase
    endfunction

    board_pkg::gpio_reg_e       wr_sel;
    board_pkg::gpio_reg_e       rd_sel;
    board_pkg::axil_resp_e      wr_resp;
    board_pkg::axil_resp_e      rd_resp;
    logic [`AXIL_DATA_W-1:0]    rd_data;
    logic [`SW_W:0]             sw_q;       // sensor + switch sample
    logic                       wr_ready;
    logic                       wr_fire;
    logic                       rd_fire;

    assign wr_sel  = decode(awaddr);
    assign rd_sel  = decode(araddr);

    assign awready = wr_ready;   // aw and w always accepted together
    assign wready  = wr_ready;
    assign arready = !rvalid;

    assign wr_fire = wr_ready && awvalid && wvalid;
    assign rd_fire = arvalid && arready;

    // input sample, one per cycle
    always_ff @(posedge clk) begin
        sw_q <= {sensor_int, sw};
    end

    // ======================================================================
    // write path
    // ======================================================================
    always_comb begin
        case (wr_sel)
            board_pkg::REG_LED,
            board_pkg::REG_DIGIT_EN: wr_resp = board_pkg::OKAY;
            board_pkg::REG_SWITCH,
            board_pkg::REG_ID:       wr_resp = board_pkg::SLVERR;
            default:                 wr_resp = board_pkg::DECERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sys_rst_n) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
            led_reg  <= '0;
            digit_en <= '0;
        end else begin
            // one-cycle ready pulse, held off while a response is pending
            wr_ready <= !wr_ready && awvalid && wvalid && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
                if (wr_sel == board_pkg::REG_LED) begin
                    for (int i = 0; i < `AXIL_STRB_W; i++) begin
                        if (wstrb[i]) led_reg[8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
                if (wr_sel == board_pkg::REG_DIGIT_EN && wstrb[0]) begin
                    digit_en <= wdata[7:0];   // upper bytes not stored
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) bresp <= wr_resp;
    end

    // ======================================================================
    // read path
    // ======================================================================
    always_comb begin
        rd_resp = board_pkg::OKAY;
        case (rd_sel)
            board_pkg::REG_LED:      rd_data = led_reg;
            board_pkg::REG_SWITCH:   rd_data = {sw_q[`SW_W], {(`AXIL_DATA_W - `SW_W - 1){1'b0}},
                                                sw_q[`SW_W-1:0]};
            board_pkg::REG_DIGIT_EN: rd_data = {{(`AXIL_DATA_W - 8){1'b0}}, digit_en};
            board_pkg::REG_ID:       rd_data = `BOARD_ID;
            default: begin
                rd_data = '0;
                rd_resp = board_pkg::DECERR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sys_rst_n)            rvalid <= 1'b0;
        else if (rd_fire)          rvalid <= 1'b1;
        else if (rready)           rvalid <= 1'b0;   // rvalid high here, accepted
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

`default_nettype wire

// ==== src/seg7_lut_8.sv ====
`timescale 1ns/1ns
`default_nettype none

module seg7_lut_8 (
    input  wire  [31:0] value,
    input  wire  [7:0]  digit_en,
    output logic [6:0]  hex0,
    output logic [6:0]  hex1,
    output logic [6:0]  hex2,
    output logic [6:0]  hex3,
    output logic [6:0]  hex4,
    output logic [6:0]  hex5,
    output logic [6:0]  hex6,
    output logic [6:0]  hex7
);

    // segments gfedcba, low = lit
    function automatic logic [6:0] seg_of(input logic [3:0] nib, input logic en);
        logic [6:0] seg;
        case (nib)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b0000011;
            4'hC: seg = 7'b1000110;
            4'hD: seg = 7'b0100001;
            4'hE: seg = 7'b0000110;
            default: seg = 7'b0001110;   // F
        endcase
        return en ? seg : 7'b1111111;    // blank when disabled
    endfunction

    assign hex0 = seg_of(value[3:0],   digit_en[0]);
    assign hex1 = seg_of(value[7:4],   digit_en[1]);
    assign hex2 = seg_of(value[11:8],  digit_en[2]);
    assign hex3 = seg_of(value[15:12], digit_en[3]);
    assign hex4 = seg_of(value[19:16], digit_en[4]);
    assign hex5 = seg_of(value[23:20], digit_en[5]);
    assign hex6 = seg_of(value[27:24], digit_en[6]);
    assign hex7 = seg_of(value[31:28], digit_en[7]);

endmodule

`default_nettype wire

// ==== src/board_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "board_macros.svh"

module board_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          pll_locked,
    input  wire  [3:0]                   key,        // key[0] is the reset button
    input  wire  [`SW_W-1:0]             sw,
    input  wire                          sensor_int,

    // AXI4-Lite slave port
    input  wire  [`AXIL_ADDR_W-1:0]      awaddr,
    input  wire                          awvalid,
    output logic                         awready,
    input  wire  [`AXIL_DATA_W-1:0]      wdata,
    input  wire  [`AXIL_STRB_W-1:0]      wstrb,
    input  wire                          wvalid,
    output logic                         wready,
    output board_pkg::axil_resp_e        bresp,
    output logic                         bvalid,
    input  wire                          bready,
    input  wire  [`AXIL_ADDR_W-1:0]      araddr,
    input  wire                          arvalid,
    output logic                         arready,
    output logic [`AXIL_DATA_W-1:0]      rdata,
    output board_pkg::axil_resp_e        rresp,
    output logic                         rvalid,
    input  wire                          rready,

    // board outputs
    output logic [17:0]                  ledr,
    output logic [8:0]                   ledg,
    output logic [6:0]                   hex0,
    output logic [6:0]                   hex1,
    output logic [6:0]                   hex2,
    output logic [6:0]                   hex3,
    output logic [6:0]                   hex4,
    output logic [6:0]                   hex5,
    output logic [6:0]                   hex6,
    output logic [6:0]                   hex7,
    output logic                         enet_rst_n
);

    logic                        sys_rst_n;
    logic [`AXIL_DATA_W-1:0]     led_reg;
    logic [7:0]                  digit_en;

    // ======================================================================
    // reset, register block, display
    // ======================================================================
    reset_ctrl u_reset_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .pll_locked (pll_locked),
        .key0       (key[0]),
        .sys_rst_n  (sys_rst_n)
    );

    axil_gpio_regs u_regs (
        .clk        (clk),
        .sys_rst_n  (sys_rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .sw         (sw),
        .sensor_int (sensor_int),
        .led_reg    (led_reg),
        .digit_en   (digit_en)
    );

    seg7_lut_8 u_segs (
        .value    (led_reg),
        .digit_en (digit_en),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .hex4     (hex4),
        .hex5     (hex5),
        .hex6     (hex6),
        .hex7     (hex7)
    );

    assign {ledr, ledg} = led_reg[26:0];   // green bank in the low bits
    assign enet_rst_n   = sys_rst_n;       // phy held with the rest of the board

endmodule

`default_nettype wire

// ==== sim/board_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "board_macros.svh"

module board_properties (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          sys_rst_n,
    input board_pkg::rst_state_e        rst_state,
    input wire [`AXIL_ADDR_W-1:0]       awaddr,
    input wire                          awvalid, awready,
    input wire [`AXIL_DATA_W-1:0]       wdata,
    input wire                          wvalid, wready,
    input wire [1:0]                    bresp,
    input wire                          bvalid, bready,
    input wire [`AXIL_ADDR_W-1:0]       araddr,
    input wire                          arvalid, arready,
    input wire [`AXIL_DATA_W-1:0]       rdata,
    input wire [1:0]                    rresp,
    input wire                          rvalid, rready
);

    int fail_count = 0;   // failed assertions so far

    task automatic flag_failure(input string msg);
        $error("%s", msg);
        fail_count++;
    endtask

    // ======================================================================
    // valid and payload held until ready
    // ======================================================================
    assert property (@(posedge clk) disable iff (!sys_rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else flag_failure("awvalid or awaddr changed before awready");
    assert property (@(posedge clk) disable iff (!sys_rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else flag_failure("wvalid or wdata changed before wready");
    assert property (@(posedge clk) disable iff (!sys_rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else flag_failure("arvalid or araddr changed before arready");
    assert property (@(posedge clk) disable iff (!sys_rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else flag_failure("bvalid or bresp changed before bready");
    assert property (@(posedge clk) disable iff (!sys_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else flag_failure("rvalid, rdata or rresp changed before rready");

    // reset behavior
    assert property (@(posedge clk) disable iff (!rst_n)
        !sys_rst_n |=> !bvalid && !rvalid)
        else flag_failure("response valid high during internal reset");
    assert property (@(posedge clk) disable iff (!rst_n)
        rst_state != board_pkg::RUN |-> !sys_rst_n)
        else flag_failure("sys_rst_n high outside RUN");

endmodule

bind board_top board_properties props (
    .rst_state (u_reset_ctrl.state),
    .*
);

`default_nettype wire

// ==== sim/board_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "board_macros.svh"

module board_monitor (
    input wire                    clk,
    input board_pkg::axil_resp_e  bresp,
    input wire                    bvalid,
    input wire                    bready,
    input wire [31:0]             rdata,
    input board_pkg::axil_resp_e  rresp,
    input wire                    rvalid,
    input wire                    rready,
    input wire [17:0]             ledr,
    input wire [8:0]              ledg,
    input wire [6:0]              hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7
);

    // lit segments gfedcba for F down to 0, active high
    localparam logic [111:0] SEG_ON = {
        7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F, 7'h7F,
        7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F
    };

    logic [1:0]  got_bresp;
    logic [1:0]  got_rresp;
    logic [31:0] got_rdata;
    logic [31:0] exp_led = '0;
    logic [7:0]  exp_den = '0;
    int          error_count = 0;
    int          test_count = 0;
    int          test_errs = 0;

    // capture responses on their handshake edge
    always @(posedge clk) begin
        if (bvalid && bready) got_bresp <= bresp;
        if (rvalid && rready) begin
            got_rresp <= rresp;
            got_rdata <= rdata;
        end
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
            error_count++;
            test_errs++;
        end
    endtask

    task automatic check_pins();
        logic [55:0] hex_bus;
        logic [3:0]  nib;
        logic [6:0]  exp_seg;
        hex_bus = {hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0};
        compare("ledg", exp_led[8:0], ledg);
        compare("ledr", exp_led[26:9], ledr);
        for (int i = 0; i < 8; i++) begin
            nib     = exp_led[4*i +: 4];
            exp_seg = exp_den[i] ? ~SEG_ON[7*nib +: 7] : 7'h7F;   // blank = all high
            compare($sformatf("hex%0d", i), exp_seg, hex_bus[7*i +: 7]);
        end
    endtask

    task automatic finish_test(input string what);
        test_count++;
        $display("test %0d %s: %s", test_count, what, (test_errs == 0) ? "ok" : "FAILED");
        test_errs = 0;
    endtask

    task automatic check_release(input int cycles);
        compare("enet_rst_n release cycles", 18, cycles);   // 2 sync + 16 hold
        finish_test("reset release");
    endtask

    task automatic check_test(input logic is_wr, input logic [3:0] addr,
                              input logic [31:0] data, input logic [3:0] strb,
                              input logic [1:0] resp, input logic [31:0] expv);
        if (is_wr) begin
            compare("bresp", resp, got_bresp);
            exp_led = expv;
            if (addr == `REG_DIGIT_EN_OFS && resp == board_pkg::OKAY && strb[0]) begin
                exp_den = data[7:0];
            end
        end else begin
            compare("rresp", resp, got_rresp);
            compare("rdata", expv, got_rdata);
        end
        check_pins();
        finish_test($sformatf("%s addr 0x%h", is_wr ? "write" : "read", addr));
    endtask

endmodule

`default_nettype wire

// ==== sim/board_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "board_macros.svh"

module board_tb;

    localparam int WAIT_LIMIT = 64;   // cycles allowed per handshake

    logic                      clk;
    logic                      rst_n;
    logic                      pll_locked;
    logic [3:0]                key;
    logic [`SW_W-1:0]          sw;
    logic                      sensor_int;
    logic [`AXIL_ADDR_W-1:0]   awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [`AXIL_DATA_W-1:0]   wdata;
    logic [`AXIL_STRB_W-1:0]   wstrb;
    logic                      wvalid;
    logic                      wready;
    board_pkg::axil_resp_e     bresp;
    logic                      bvalid;
    logic                      bready;
    logic [`AXIL_ADDR_W-1:0]   araddr;
    logic                      arvalid;
    logic                      arready;
    logic [`AXIL_DATA_W-1:0]   rdata;
    board_pkg::axil_resp_e     rresp;
    logic                      rvalid;
    logic                      rready;
    logic [17:0]               ledr;
    logic [8:0]                ledg;
    logic [6:0]                hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;
    logic                      enet_rst_n;

    logic [31:0]               lfsr = 32'h8103;
    int                        failures = 0;   // timeouts and file problems

    board_top uut (.*);

    board_monitor mon (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // helpers
    // ======================================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // ready stall of 0..3 cycles, two lfsr bits
    task automatic stall_cycles(output int cycles);
        cycles = 0;
        repeat (2) begin
            lfsr   = lfsr_next(lfsr);
            cycles = cycles * 2 + lfsr[0];
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;   // drive just after the edge
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not arrive within %0d cycles", what, WAIT_LIMIT);
        failures++;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic hs;
        int   n;
        int   stall;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        hs = 1'b0;
        n  = 0;
        while (!hs && n < WAIT_LIMIT) begin
            hs = awready && wready;   // handshake on the coming edge
            next_cycle();
            n++;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!hs) begin
            report_timeout("awready/wready");
        end else begin
            stall_cycles(stall);
            repeat (stall) next_cycle();
            bready = 1'b1;
            hs = 1'b0;
            n  = 0;
            while (!hs && n < WAIT_LIMIT) begin
                hs = bvalid;
                next_cycle();
                n++;
            end
            bready = 1'b0;
            if (!hs) report_timeout("bvalid");
        end
    endtask

    task automatic axi_read(input logic [3:0] addr);
        logic hs;
        int   n;
        int   stall;
        araddr  = addr;
        arvalid = 1'b1;
        hs = 1'b0;
        n  = 0;
        while (!hs && n < WAIT_LIMIT) begin
            hs = arready;
            next_cycle();
            n++;
        end
        arvalid = 1'b0;
        if (!hs) begin
            report_timeout("arready");
        end else begin
            stall_cycles(stall);
            repeat (stall) next_cycle();
            rready = 1'b1;
            hs = 1'b0;
            n  = 0;
            while (!hs && n < WAIT_LIMIT) begin
                hs = rvalid;
                next_cycle();
                n++;
            end
            rready = 1'b0;
            if (!hs) report_timeout("rvalid");
        end
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        logic [7:0]  op;
        logic [31:0] addr_v, data_v, strb_v, sw_v, sens_v, resp_v, exp_v;
        int          fd;
        int          fields;
        int          cnt;
        string       line;

        rst_n      = 1'b0;
        pll_locked = 1'b1;
        key        = 4'h0;       // reset button pressed
        sw         = '0;
        sensor_int = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;

        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (5) next_cycle();
        key = 4'hF;              // button released, count from here

        cnt = 0;
        while (!enet_rst_n && cnt < WAIT_LIMIT) begin
            next_cycle();
            cnt++;
            mon.check_pins();    // digits stay blank
        end
        if (!enet_rst_n) report_timeout("enet_rst_n release");
        else             mon.check_release(cnt);

        fd = $fopen("sim/board_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/board_golden.txt");
            failures++;
        end else begin
            while (failures == 0 && $fgets(line, fd)) begin
                if (line.len() < 2 || line[0] == "#") continue;
                fields = $sscanf(line, "%c %h %h %h %h %h %h %h", op, addr_v, data_v,
                                 strb_v, sw_v, sens_v, resp_v, exp_v);
                if (fields != 8) begin
                    $display("golden line has %0d fields instead of 8: %s", fields, line);
                    failures++;
                end else begin
                    sw         = sw_v[`SW_W-1:0];
                    sensor_int = sens_v[0];
                    repeat (2) next_cycle();   // let the sample register settle
                    if (op == "w") axi_write(addr_v[3:0], data_v, strb_v[3:0]);
                    else           axi_read(addr_v[3:0]);
                    if (failures == 0) begin
                        mon.check_test(op == "w", addr_v[3:0], data_v, strb_v[3:0],
                                       resp_v[1:0], exp_v);
                    end
                end
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d mismatches, %0d assertion failures, %0d other failures",
                 mon.test_count, mon.error_count, uut.props.fail_count, failures);
        if (failures == 0 && mon.error_count == 0 && uut.props.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/board_golden.txt ====
# op addr data strb sw sensor resp expect
# expect is the LED register after a write, the read data after a read
w 0 01234567 f 00000 0 0 01234567
w 0 00ab0000 4 00000 0 0 01ab4567
r 0 00000000 0 00000 0 0 01ab4567
w 0 76543210 f 00000 0 0 76543210
w 8 000000a5 1 00000 0 0 76543210
w 8 000000ff f 00000 0 0 76543210
w 0 fedcba98 f 00000 0 0 fedcba98
r 8 00000000 0 00000 0 0 000000ff
w 4 12345678 f 00000 0 2 fedcba98
w 6 12345678 f 00000 0 3 fedcba98
r 0 00000000 0 00000 0 0 fedcba98
r 8 00000000 0 00000 0 0 000000ff
r 6 00000000 0 00000 0 3 00000000
r 4 00000000 0 2a5c3 1 0 8002a5c3
r 4 00000000 0 15a3c 0 0 00015a3c
r c 00000000 0 00000 0 0 5ec70001
w 0 11111111 f 00000 0 0 11111111
w 0 22222222 f 00000 0 0 22222222
w 0 00000033 1 00000 0 0 22222233
r 0 00000000 0 00000 0 0 22222233
w 8 00000000 1 00000 0 0 22222233

// ==== list.f ====
+incdir+src
src/board_pkg.sv
src/reset_ctrl.sv
src/axil_gpio_regs.sv
src/seg7_lut_8.sv
src/board_top.sv
sim/board_properties.sv
sim/board_monitor.sv
sim/board_tb.sv
